// File: Makefile
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_rv_ctrl
FILELIST   = build.f
BUILD_DIR  = obj_dir
PASS_MSG   = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: build.f
source/rv_ctrl_pkg.sv
source/instr_decoder.sv
source/decode_fifo.sv
source/stage_sequencer.sv
source/rv_ctrl_top.sv
sim/tb_rv_ctrl.sv

// File: sim/rv_ctrl_golden.txt
# instr_hex stages ctrl_fetch ctrl_decode ctrl_execute ctrl_4th ctrl_5th
# ctrl words in 18-bit hex in stage order, unused columns are 00000
123450B7 4 00000 34000 20520 20003 00000
0040A183 5 00000 28000 20020 20010 20007
0020A423 4 00000 2C000 20020 20008 00000
00208463 3 00000 30000 20800 00000 00000
00001117 4 00000 34000 20060 20003 00000
008000EF 4 00000 38000 20000 22001 00000
000100E7 4 00000 28000 20000 21001 00000
00209463 3 00000 30000 20800 00000 00000
0020C463 3 00000 30000 20800 00000 00000
0020D463 3 00000 30000 20800 00000 00000
0020E463 3 00000 30000 20800 00000 00000
0020F463 3 00000 30000 20800 00000 00000
00408183 5 00000 28000 20020 20010 20007
00409183 5 00000 28000 20020 20010 20007
00000000 2 00000 00000 00000 00000 00000
0040C183 5 00000 28000 20020 20010 20007
0040D183 5 00000 28000 20020 20010 20007
00208423 4 00000 2C000 20020 20008 00000
00209423 4 00000 2C000 20020 20008 00000
00108293 4 00000 28000 20020 20003 00000
0010A293 4 00000 28000 201A0 20003 00000
0010B293 4 00000 28000 20220 20003 00000
0010C293 4 00000 28000 202A0 20003 00000
0010E293 4 00000 28000 20420 20003 00000
4020C333 2 00000 00000 00000 00000 00000
0010F293 4 00000 28000 204A0 20003 00000
00109293 4 00000 28000 20120 20003 00000
0010D293 4 00000 28000 20320 20003 00000
4010D293 4 00000 28000 203A0 20003 00000
00208333 4 00000 24000 20000 20003 00000
40208333 4 00000 24000 20080 20003 00000
00209333 4 00000 24000 20100 20003 00000
0020A333 4 00000 24000 20180 20003 00000
0020B333 4 00000 24000 20200 20003 00000
0020C333 4 00000 24000 20280 20003 00000
0020D333 4 00000 24000 20300 20003 00000
4020D333 4 00000 24000 20380 20003 00000
0020E333 4 00000 24000 20400 20003 00000
0020F333 4 00000 24000 20480 20003 00000
0040B183 2 00000 00000 00000 00000 00000

// File: sim/tb_rv_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_ctrl import rv_ctrl_pkg::*;
();

    localparam int    CLK_HALF        = 2;
    localparam int    RESET_CYCLES    = 8;
    localparam int    DRIVE_DELAY     = 1;
    localparam int    MAX_LINES       = 64;
    localparam int    MAX_STAGES      = 5;
    localparam int    CYCLES_PER_LINE = 20;
    localparam int    DRAIN_PAUSE     = 6;
    localparam string GOLDEN_FILE     = "sim/rv_ctrl_golden.txt";

    logic        CLK;
    logic        RESET;
    logic        ins_valid;
    instr_t      ins;
    logic        ins_credit;
    stage_t      stage;
    ctrl_word_t  ctrl;

    instr_t      gold_ins   [MAX_LINES];
    int          gold_count [MAX_LINES];
    ctrl_word_t  gold_ctrl  [MAX_LINES][MAX_STAGES];
    int          issue_edge [MAX_LINES];                // Edge that samples ins_valid
    int          n_lines = 0;
    int          n_issued;
    int          cycle = 0;
    int          credits;
    int          credit_pulses;
    logic        golden_loaded = 1'b0;
    logic        checks_done;
    logic [31:0] rand_state;

    rv_ctrl_top i_dut (
        .CLK        (CLK),
        .RESET      (RESET),
        .ins_valid  (ins_valid),
        .ins        (ins),
        .ins_credit (ins_credit),
        .stage      (stage),
        .ctrl       (ctrl)
    );

    initial
    begin
        CLK = 1'b0;
        forever
        begin
            #CLK_HALF CLK = ~CLK;
        end
    end

    always @(posedge CLK)
    begin
        cycle <= cycle + 1;
    end

    //////////////////////////////
    // Reporting and compares

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_ctrl(input ctrl_word_t got, input ctrl_word_t exp, input string what);
        if (got !== exp)
        begin
            fail_run($sformatf("** Error @ %0t: %s ctrl %05h, expected %05h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_stage(input stage_t got, input stage_t exp, input string what);
        if (got !== exp)
        begin
            fail_run($sformatf("** Error @ %0t: %s stage %s, expected %s",
                               $time, what, got.name(), exp.name()));
        end
    endtask

    task automatic check_credits(input int got, input int exp, input string what);
        if (got != exp)
        begin
            fail_run($sformatf("** Error @ %0t: %s is %0d, expected %0d",
                               $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Stores stop in memory, loads run on to write-back
    function automatic stage_t expected_stage(input instr_t word, input int count, input int k);
        case (k)
            0:       return ST_FETCH;
            1:       return ST_DECODE;
            2:       return ST_EXECUTE;
            3:       return (count == 5 || word[6:0] == OPC_STORE) ? ST_MEMORY : ST_WRITE_BACK;
            default: return ST_WRITE_BACK;
        endcase
    endfunction

    task automatic load_golden();
        int          fd;
        int          fields;
        int          count;
        int          k;
        string       line;
        logic [31:0] word;
        logic [31:0] col [MAX_STAGES];
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0)
        begin
            fail_run("Could not open the golden data file");
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line.getc(0) == "#")
            begin
                continue;                               // Blank or column note
            end
            fields = $sscanf(line, "%h %d %h %h %h %h %h",
                             word, count, col[0], col[1], col[2], col[3], col[4]);
            if (fields != 7 || count < 2 || count > MAX_STAGES || n_lines == MAX_LINES)
            begin
                fail_run($sformatf("Golden data line could not be read: %s", line));
            end
            gold_ins[n_lines]   = word;
            gold_count[n_lines] = count;
            for (k = 0; k < MAX_STAGES; k++)
            begin
                gold_ctrl[n_lines][k] = ctrl_word_t'(col[k][17:0]);
            end
            n_lines++;
        end
        $fclose(fd);
        if (n_lines == 0)
        begin
            fail_run("Golden data file holds no instructions");
        end
    endtask

    //////////////////////////////
    // Upstream side

    task automatic collect_credit_cycle();
        @(posedge CLK);
        #DRIVE_DELAY;
        if (ins_credit)
        begin
            credits++;
            credit_pulses++;
        end
        if (credits > FIFO_DEPTH)
        begin
            fail_run("Returned credits pushed the upstream count above the queue depth");
        end
    endtask

    task automatic issue_all();
        int i;
        int gap;
        for (i = 0; i < n_lines; i++)
        begin
            gap = 0;
            if (i >= FIFO_DEPTH)                        // First burst goes back to back
            begin
                rand_state = xorshift32(rand_state);
                gap        = int'(rand_state % 4);
            end
            if (i == n_lines / 2)
            begin
                // Let the queue drain so the sequencer idles mid-run
                while (credits < FIFO_DEPTH)
                begin
                    collect_credit_cycle();
                end
                repeat (DRAIN_PAUSE) collect_credit_cycle();
            end
            repeat (gap) collect_credit_cycle();
            while (credits == 0)
            begin
                collect_credit_cycle();
            end
            ins_valid     = 1'b1;
            ins           = gold_ins[i];
            issue_edge[i] = cycle + 1;
            n_issued      = i + 1;
            credits--;
            collect_credit_cycle();
            ins_valid     = 1'b0;
        end
        while (!checks_done)
        begin
            collect_credit_cycle();
        end
    endtask

    //////////////////////////////
    // Sequencer side

    task automatic check_all();
        int    n;
        int    k;
        string what;
        check_stage(stage, ST_IDLE, "after reset");
        check_ctrl(ctrl, '0, "after reset");
        check_credits(int'(ins_credit), 0, "ins_credit after reset");
        for (n = 0; n < n_lines; n++)
        begin
            while (stage == ST_IDLE)
            begin
                // Entry reaches the queue head two edges after issue
                if (n < n_issued && cycle >= issue_edge[n] + 2)
                begin
                    fail_run($sformatf("Sequencer idled at %0t with instruction %0d queued",
                                       $time, n));
                end
                check_ctrl(ctrl, '0, "idle");
                check_credits(int'(ins_credit), 0, "ins_credit while idle");
                @(posedge CLK);
                #DRIVE_DELAY;
            end
            if (n >= n_issued || cycle < issue_edge[n] + 2)
            begin
                fail_run($sformatf("Sequencer fetched at %0t before instruction %0d was queued",
                                   $time, n));
            end
            for (k = 0; k < gold_count[n]; k++)
            begin
                what = $sformatf("instr %0d (%08h) step %0d", n, gold_ins[n], k);
                check_stage(stage, expected_stage(gold_ins[n], gold_count[n], k), what);
                check_ctrl(ctrl, gold_ctrl[n][k], what);
                check_credits(int'(ins_credit), (k == 0) ? 1 : 0, {what, " ins_credit"});
                @(posedge CLK);
                #DRIVE_DELAY;
            end
        end
        check_stage(stage, ST_IDLE, "after the last instruction");
        check_ctrl(ctrl, '0, "after the last instruction");
        checks_done = 1'b1;
    endtask

    initial
    begin
        RESET         = 1'b1;
        ins_valid     = 1'b0;
        ins           = '0;
        credits       = FIFO_DEPTH;
        credit_pulses = 0;
        n_issued      = 0;
        checks_done   = 1'b0;
        rand_state    = 32'd8649;
        load_golden();
        golden_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DELAY;
        RESET = 1'b0;
        fork
            issue_all();
            check_all();
        join
        check_credits(credit_pulses, n_lines, "ins_credit pulses in total");
        $display("All tests passed!");
        $finish;
    end

    // Watchdog
    initial
    begin
        wait (golden_loaded);
        repeat (RESET_CYCLES + CYCLES_PER_LINE * n_lines) @(posedge CLK);
        fail_run($sformatf("Run timed out after %0d cycles", cycle));
    end

endmodule

`default_nettype wire

// File: source/decode_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module decode_fifo import rv_ctrl_pkg::*;
(
    input  logic           CLK,
    input  logic           RESET,
    input  logic           push,
    input  decoded_instr_t push_entry,
    input  logic           pop,
    output logic           empty,
    output decoded_instr_t head
);

    decoded_instr_t        mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  full;

    function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] ptr);
        if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign head  = mem[rd_ptr];                         // Head shows one cycle after push

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop)
            begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_entry;
        end
    end

    // The upstream credit count must keep the queue from overflowing
    push_not_full: assert property (@(posedge CLK) disable iff (RESET) push |-> !full)
        else $error("decode_fifo push while full");

    pop_not_empty: assert property (@(posedge CLK) disable iff (RESET) pop |-> !empty)
        else $error("decode_fifo pop while empty");

endmodule

`default_nettype wire

// File: source/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder import rv_ctrl_pkg::*;
(
    input  logic           CLK,
    input  logic           RESET,
    input  logic           ins_valid,
    input  instr_t         ins,
    output logic           dec_valid,
    output decoded_instr_t dec_entry
);

    ins_key_t       key;
    logic           is_reg;
    alu_op_t        alu_sel;
    logic           alu_legal;
    decoded_instr_t entry;

    assign key    = {ins[30], ins[14:12], ins[6:0]};
    assign is_reg = (key.opcode == OPC_OP);

    // ALU operation, shared by the immediate and register groups
    always_comb
    begin
        alu_sel   = ALU_ADD;
        alu_legal = !is_reg || (key.b30 == B30_BASE);   // Bit 30 is immediate data for I-type
        case (key.funct3)
            F3_ADD:
            begin
                alu_legal = 1'b1;
                if (is_reg && key.b30 == B30_ALT)
                begin
                    alu_sel = ALU_SUB;
                end
            end
            F3_SLL:
            begin
                alu_sel   = ALU_SLL;
                alu_legal = (key.b30 == B30_BASE);
            end
            F3_SLT:  alu_sel = ALU_SLT;
            F3_SLTU: alu_sel = ALU_SLTU;
            F3_XOR:  alu_sel = ALU_XOR;
            F3_SR:
            begin
                alu_legal = 1'b1;
                alu_sel   = ALU_SRL;
                if (key.b30 == B30_ALT)
                begin
                    alu_sel = ALU_SRA;
                end
            end
            F3_OR:   alu_sel = ALU_OR;
            F3_AND:  alu_sel = ALU_AND;
        endcase
    end

    always_comb
    begin
        entry = '{OP_ILLEGAL, FMT_NONE, ALU_ADD, SRC1_RS1, SRC2_RS2};
        case (key.opcode)
            OPC_LUI:    entry = '{OP_LUI, FMT_U, ALU_COPY2, SRC1_RS1, SRC2_IMM};
            OPC_AUIPC:  entry = '{OP_AUIPC, FMT_U, ALU_ADD, SRC1_PC, SRC2_IMM};
            OPC_JAL:    entry = '{OP_JAL, FMT_J, ALU_ADD, SRC1_RS1, SRC2_RS2};
            OPC_JALR:
            begin
                if (key.funct3 == F3_JALR)
                begin
                    entry = '{OP_JALR, FMT_I, ALU_ADD, SRC1_RS1, SRC2_RS2};
                end
            end
            OPC_BRANCH: entry = '{OP_BRANCH, FMT_B, ALU_ADD, SRC1_RS1, SRC2_RS2};  // Any funct3
            OPC_LOAD:
            begin
                if (key.funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU})
                begin
                    entry = '{OP_LOAD, FMT_I, ALU_ADD, SRC1_RS1, SRC2_IMM};
                end
            end
            OPC_STORE:
            begin
                if (key.funct3 inside {F3_SB, F3_SH, F3_SW})
                begin
                    entry = '{OP_STORE, FMT_S, ALU_ADD, SRC1_RS1, SRC2_IMM};
                end
            end
            OPC_OP_IMM:
            begin
                if (alu_legal)
                begin
                    entry = '{OP_ALU_IMM, FMT_I, alu_sel, SRC1_RS1, SRC2_IMM};
                end
            end
            OPC_OP:
            begin
                if (alu_legal)
                begin
                    entry = '{OP_ALU_REG, FMT_R, alu_sel, SRC1_RS1, SRC2_RS2};
                end
            end
            default: ;                                  // Stays illegal
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            dec_valid <= 1'b0;
        end
        else
        begin
            dec_valid <= ins_valid;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (ins_valid)
        begin
            dec_entry <= entry;
        end
    end

endmodule

`default_nettype wire

// File: source/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

    //////////////////////////////
    // Widths and sizes

    localparam int INSTR_W    = 32;
    localparam int FIFO_DEPTH = 4;                      // Also the upstream's starting credits
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [6:0]         opcode_t;
    typedef logic [2:0]         funct3_t;

    //////////////////////////////
    // Opcodes, funct3, bit 30

    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    localparam funct3_t F3_JALR = 3'b000;

    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

    localparam funct3_t F3_ADD  = 3'b000;               // ADD and SUB
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;               // SRL and SRA
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam logic B30_BASE = 1'b0;
    localparam logic B30_ALT  = 1'b1;                   // SUB, SRA, SRAI

    //////////////////////////////
    // Types

    typedef struct packed {
        logic    b30;
        funct3_t funct3;
        opcode_t opcode;
    } ins_key_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_COPY2
    } alu_op_t;

    typedef enum logic [2:0] {
        FMT_NONE, FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J
    } imm_type_t;

    typedef enum logic {SRC1_RS1, SRC1_PC}  alu_src1_t;
    typedef enum logic {SRC2_RS2, SRC2_IMM} alu_src2_t;

    typedef enum logic [3:0] {
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
        OP_LOAD, OP_STORE, OP_ALU_IMM, OP_ALU_REG, OP_ILLEGAL
    } op_class_t;

    typedef struct packed {
        op_class_t op_class;
        imm_type_t imm_type;
        alu_op_t   alu_op;
        alu_src1_t alu_src1;
        alu_src2_t alu_src2;
    } decoded_instr_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_DECODE, ST_EXECUTE, ST_MEMORY, ST_WRITE_BACK
    } stage_t;

    typedef struct packed {
        logic      stall;
        imm_type_t imm_type;
        logic      jump;
        logic      jump_reg;
        logic      branch;
        alu_op_t   alu_op;
        alu_src1_t alu_src1;
        alu_src2_t alu_src2;
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;
        logic      wrt_src;
        logic      reg_write;
    } ctrl_word_t;

endpackage

`default_nettype wire

// File: source/rv_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_ctrl_top import rv_ctrl_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       ins_valid,
    input  instr_t     ins,
    output logic       ins_credit,
    output stage_t     stage,
    output ctrl_word_t ctrl
);

    logic           dec_valid;
    decoded_instr_t dec_entry;
    logic           q_empty;
    decoded_instr_t q_entry;
    logic           q_pop;

    instr_decoder i_decoder (
        .CLK       (CLK),
        .RESET     (RESET),
        .ins_valid (ins_valid),
        .ins       (ins),
        .dec_valid (dec_valid),
        .dec_entry (dec_entry)
    );

    decode_fifo i_fifo (
        .CLK        (CLK),
        .RESET      (RESET),
        .push       (dec_valid),
        .push_entry (dec_entry),
        .pop        (q_pop),
        .empty      (q_empty),
        .head       (q_entry)
    );

    stage_sequencer i_sequencer (
        .CLK        (CLK),
        .RESET      (RESET),
        .q_empty    (q_empty),
        .q_entry    (q_entry),
        .q_pop      (q_pop),
        .ins_credit (ins_credit),
        .stage      (stage),
        .ctrl       (ctrl)
    );

endmodule

`default_nettype wire

// File: source/stage_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module stage_sequencer import rv_ctrl_pkg::*;
(
    input  logic           CLK,
    input  logic           RESET,
    input  logic           q_empty,
    input  decoded_instr_t q_entry,
    output logic           q_pop,
    output logic           ins_credit,
    output stage_t         stage,
    output ctrl_word_t     ctrl
);

    decoded_instr_t cur_entry;
    stage_t         stage_next;
    ctrl_word_t     ctrl_next;
    logic           seq_done;
    logic           illegal_decode;

    //////////////////////////////
    // Next stage

    always_comb
    begin
        seq_done   = 1'b0;
        stage_next = stage;
        case (stage)
            ST_FETCH:      stage_next = ST_DECODE;
            ST_DECODE:
            begin
                if (cur_entry.op_class == OP_ILLEGAL)
                begin
                    seq_done = 1'b1;
                end
                else
                begin
                    stage_next = ST_EXECUTE;
                end
            end
            ST_EXECUTE:
            begin
                case (cur_entry.op_class)
                    OP_LOAD, OP_STORE: stage_next = ST_MEMORY;
                    OP_BRANCH:         seq_done   = 1'b1;
                    default:           stage_next = ST_WRITE_BACK;
                endcase
            end
            ST_MEMORY:
            begin
                if (cur_entry.op_class == OP_LOAD)
                begin
                    stage_next = ST_WRITE_BACK;
                end
                else
                begin
                    seq_done = 1'b1;                    // Stores end here
                end
            end
            default:       seq_done = 1'b1;             // Idle or write-back
        endcase
        if (seq_done)
        begin
            stage_next = q_empty ? ST_IDLE : ST_FETCH;
        end
    end

    assign q_pop = seq_done && !q_empty;

    //////////////////////////////
    // Control word for the next stage

    always_comb
    begin
        ctrl_next = '0;
        case (stage_next)
            ST_FETCH:
            begin
                ctrl_next.alu_op   = ALU_ADD;           // PC + 4
                ctrl_next.alu_src1 = SRC1_RS1;
                ctrl_next.alu_src2 = SRC2_RS2;
            end
            ST_DECODE:
            begin
                if (cur_entry.op_class != OP_ILLEGAL)
                begin
                    ctrl_next.stall    = 1'b1;
                    ctrl_next.imm_type = cur_entry.imm_type;
                end
            end
            ST_EXECUTE:
            begin
                ctrl_next.stall    = 1'b1;
                ctrl_next.branch   = (cur_entry.op_class == OP_BRANCH);
                ctrl_next.alu_op   = cur_entry.alu_op;
                ctrl_next.alu_src1 = cur_entry.alu_src1;
                ctrl_next.alu_src2 = cur_entry.alu_src2;
            end
            ST_MEMORY:
            begin
                ctrl_next.stall     = 1'b1;
                ctrl_next.mem_read  = (cur_entry.op_class == OP_LOAD);
                ctrl_next.mem_write = (cur_entry.op_class == OP_STORE);
            end
            ST_WRITE_BACK:
            begin
                ctrl_next.stall      = 1'b1;
                ctrl_next.reg_write  = 1'b1;
                ctrl_next.jump       = (cur_entry.op_class == OP_JAL);
                ctrl_next.jump_reg   = (cur_entry.op_class == OP_JALR);
                ctrl_next.wrt_src    = !(cur_entry.op_class inside {OP_JAL, OP_JALR});
                ctrl_next.mem_to_reg = (cur_entry.op_class == OP_LOAD);
            end
            default: ctrl_next = '0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            stage      <= ST_IDLE;
            ctrl       <= '0;
            ins_credit <= 1'b0;
        end
        else
        begin
            stage      <= stage_next;
            ctrl       <= ctrl_next;
            ins_credit <= q_pop;                        // Slot freed, hand a credit back
        end
    end

    always_ff @(posedge CLK)
    begin
        if (q_pop)
        begin
            cur_entry <= q_entry;
        end
    end

    assign illegal_decode = (stage == ST_DECODE) && (cur_entry.op_class == OP_ILLEGAL);

    credit_in_fetch: assert property (@(posedge CLK) disable iff (RESET)
        ins_credit |-> (stage == ST_FETCH))
        else $error("ins_credit outside ST_FETCH");

    stall_by_stage: assert property (@(posedge CLK) disable iff (RESET)
        ctrl.stall == !((stage inside {ST_IDLE, ST_FETCH}) || illegal_decode))
        else $error("stall does not match stage");

endmodule

`default_nettype wire
